// ==== hdl/nocLink_params.svh ====
// Fixed-length packets only; FIFO_DEPTH must be a multiple of PKT_LEN and fit in CNT_W bits.
`ifndef NOCLINK_PARAMS_SVH
`define NOCLINK_PARAMS_SVH

// ============================================================
// Flit format
// ============================================================
`define FLIT_W 34
`define TYPE_MSB 33
`define TYPE_LSB 32

// ============================================================
// Virtual channels
// ============================================================
`define VC_N 2
`define VC_W 1

// ============================================================
// Buffering and packets
// ============================================================
`define FIFO_DEPTH 8
`define PKT_LEN 4
`define CNT_W 4

`endif

// ==== hdl/nocLinkPkg.sv ====
// Flit type encoding keeps NONE at zero so an idle, cleared link reads as no flit.
`default_nettype none

package nocLinkPkg;

        // Flit type in bits TYPE_MSB:TYPE_LSB of every flit.
        typedef enum logic [1:0] {
                NONE = 2'b00,
                HEAD = 2'b01,
                BODY = 2'b10,
                TAIL = 2'b11
        } flitType_e;

        // Injection arbiter.
        typedef enum logic {
                IDLE = 1'b0,
                SEND = 1'b1
        } arbState_e;

        // Packet ejector in the input buffer.
        typedef enum logic {
                EJ_IDLE = 1'b0,
                EJ_PKT  = 1'b1
        } ejState_e;

endpackage

`default_nettype wire

// ==== hdl/vcArbiter.sv ====
// Sources must present whole HEAD..TAIL packets; a grant is held until TAIL, never preempted.
`timescale 1ns/1ps
`default_nettype none

`include "nocLink_params.svh"

module vcArbiter (
        input  wire logic                             clk,
        input  wire logic                             rst,
        input  wire logic [`VC_N-1:0][`FLIT_W-1:0]    injFlit,
        input  wire logic [`VC_N-1:0]                 injValid,
        output logic      [`VC_N-1:0]                 injReady,
        input  wire logic [`VC_N-1:0]                 vcReady,
        output logic      [`FLIT_W-1:0]               sendFlit,
        output logic                                  sendValid,
        output logic      [`VC_W-1:0]                 sendVc
);

        nocLinkPkg::arbState_e state;
        logic [`VC_W-1:0] grantVc;
        logic [`VC_W-1:0] rrPtr;
        logic [`VC_W-1:0] pickVc;
        logic             pickFound;

        // Round robin search from rrPtr for a HEAD with downstream room.
        always_comb begin
                int idx;
                pickVc = '0;
                pickFound = 1'b0;
                for (int i = 0; i < `VC_N; i++) begin
                        idx = (int'(rrPtr) + i) % `VC_N;
                        if (!pickFound && injValid[idx] && vcReady[idx] &&
                            injFlit[idx][`TYPE_MSB:`TYPE_LSB] == nocLinkPkg::HEAD) begin
                                pickVc = `VC_W'(idx);
                                pickFound = 1'b1;
                        end
                end
        end

        // Only the granted VC sees ready.
        always_comb begin
                injReady = '0;
                if (state == nocLinkPkg::SEND) begin
                        injReady[grantVc] = 1'b1;
                end
        end

        assign sendValid = (state == nocLinkPkg::SEND) && injValid[grantVc];
        assign sendFlit  = injFlit[grantVc];
        assign sendVc    = grantVc;

        always_ff @(posedge clk) begin
                if (rst) begin
                        state   <= nocLinkPkg::IDLE;
                        grantVc <= '0;
                        rrPtr   <= '0;
                end else begin
                        case (state)
                                nocLinkPkg::IDLE: begin
                                        if (pickFound) begin
                                                state   <= nocLinkPkg::SEND;
                                                grantVc <= pickVc;
                                                if (pickVc == `VC_W'(`VC_N - 1)) begin
                                                        rrPtr <= '0;
                                                end else begin
                                                        rrPtr <= pickVc + 1'b1;
                                                end
                                        end
                                end
                                nocLinkPkg::SEND: begin
                                        // Release after the tail handshake.
                                        if (sendValid && sendFlit[`TYPE_MSB:`TYPE_LSB] ==
                                            nocLinkPkg::TAIL) begin
                                                state <= nocLinkPkg::IDLE;
                                        end
                                end
                                default: begin
                                        state <= nocLinkPkg::IDLE;
                                end
                        endcase
                end
        end

endmodule

`default_nettype wire

// ==== hdl/outputChannel.sv ====
// Credits track a downstream FIFO of `FIFO_DEPTH flits; an ack with no credit outstanding is dropped.
`timescale 1ns/1ps
`default_nettype none

`include "nocLink_params.svh"

module outputChannel (
        input  wire logic                  clk,
        input  wire logic                  rst,
        input  wire logic [`FLIT_W-1:0]    sendFlit,
        input  wire logic                  sendValid,
        input  wire logic [`VC_W-1:0]      sendVc,
        output logic      [`VC_N-1:0]      vcReady,
        output logic      [`VC_N-1:0]      vcLock,
        output logic      [`FLIT_W-1:0]    linkFlit,
        output logic                       linkValid,
        output logic      [`VC_W-1:0]      linkVc,
        input  wire logic [`VC_N-1:0]      linkAck,
        input  wire logic [`VC_N-1:0]      linkLock
);

        // ============================================================
        // Link register
        // ============================================================
        always_ff @(posedge clk) begin
                if (rst) begin
                        linkFlit  <= {nocLinkPkg::NONE, {(`FLIT_W - 2){1'b0}}};
                        linkValid <= 1'b0;
                        linkVc    <= '0;
                end else if (sendValid) begin
                        linkFlit  <= sendFlit;
                        linkValid <= 1'b1;
                        linkVc    <= sendVc;
                end else if (linkValid) begin
                        // Idle link reads as all zero.
                        linkFlit  <= {nocLinkPkg::NONE, {(`FLIT_W - 2){1'b0}}};
                        linkValid <= 1'b0;
                        linkVc    <= '0;
                end
        end

        // ============================================================
        // Per-VC credit and lock state
        // ============================================================
        for (genvar i = 0; i < `VC_N; i++) begin : gVc
                logic [`CNT_W-1:0] credit;
                logic              sent;
                logic              onLink;

                assign sent   = sendValid && (sendVc == `VC_W'(i));
                assign onLink = linkValid && (linkVc == `VC_W'(i));

                // Room for one whole packet.
                assign vcReady[i] = (`FIFO_DEPTH - int'(credit)) >= `PKT_LEN;

                always_ff @(posedge clk) begin
                        if (rst) begin
                                credit <= '0;
                        end else if (linkAck[i] && !sent && credit != '0) begin
                                credit <= credit - 1'b1;
                        end else if (!linkAck[i] && sent) begin
                                credit <= credit + 1'b1;
                        end
                end

                always_ff @(posedge clk) begin
                        if (rst) begin
                                vcLock[i] <= 1'b0;
                        end else if (sent || onLink) begin
                                vcLock[i] <= 1'b1;
                        end else if (vcLock[i] && !linkLock[i]) begin
                                vcLock[i] <= 1'b0;
                        end
                end
        end

endmodule

`default_nettype wire

// ==== hdl/vcInputBuffer.sv ====
// Writes are unchecked for overflow and rely on the upstream credit counter never exceeding `FIFO_DEPTH.
`timescale 1ns/1ps
`default_nettype none

`include "nocLink_params.svh"

module vcInputBuffer (
        input  wire logic                  clk,
        input  wire logic                  rst,
        input  wire logic [`FLIT_W-1:0]    linkFlit,
        input  wire logic                  linkValid,
        input  wire logic [`VC_W-1:0]      linkVc,
        output logic      [`VC_N-1:0]      linkAck,
        output logic      [`VC_N-1:0]      linkLock,
        output logic      [`FLIT_W-1:0]    ejFlit,
        output logic                       ejValid,
        output logic      [`VC_W-1:0]      ejVc,
        input  wire logic                  ejReady
);

        localparam int PTR_W = $clog2(`FIFO_DEPTH);

        nocLinkPkg::ejState_e state;
        logic [`VC_W-1:0] curVc;
        logic [`VC_W-1:0] rrPtr;
        logic [`VC_W-1:0] pickVc;
        logic             pickFound;
        logic             ejPop;
        logic [`VC_N-1:0][`FLIT_W-1:0] headFlit;
        logic [`VC_N-1:0] notEmpty;

        // ============================================================
        // Per-VC circular FIFOs
        // ============================================================
        for (genvar i = 0; i < `VC_N; i++) begin : gFifo
                logic [`FLIT_W-1:0] mem [`FIFO_DEPTH];
                logic [PTR_W-1:0]   wrPtr;
                logic [PTR_W-1:0]   rdPtr;
                logic [`CNT_W-1:0]  count;
                logic               push;

                assign push = linkValid && (linkVc == `VC_W'(i));

                always_ff @(posedge clk) begin
                        if (push) begin
                                mem[wrPtr] <= linkFlit;
                        end
                end

                always_ff @(posedge clk) begin
                        if (rst) begin
                                wrPtr <= '0;
                                rdPtr <= '0;
                                count <= '0;
                        end else begin
                                if (push) begin
                                        wrPtr <= (wrPtr == PTR_W'(`FIFO_DEPTH - 1)) ?
                                                 '0 : wrPtr + 1'b1;
                                end
                                if (linkAck[i]) begin
                                        rdPtr <= (rdPtr == PTR_W'(`FIFO_DEPTH - 1)) ?
                                                 '0 : rdPtr + 1'b1;
                                end
                                case ({push, linkAck[i]})
                                        2'b10: count <= count + 1'b1;
                                        2'b01: count <= count - 1'b1;
                                        default: count <= count;
                                endcase
                        end
                end

                assign headFlit[i] = mem[rdPtr];
                assign notEmpty[i] = (count != '0);
        end

        // ============================================================
        // Packet ejector
        // ============================================================
        always_comb begin
                int idx;
                pickVc = '0;
                pickFound = 1'b0;
                for (int i = 0; i < `VC_N; i++) begin
                        idx = (int'(rrPtr) + i) % `VC_N;
                        if (!pickFound && notEmpty[idx] &&
                            headFlit[idx][`TYPE_MSB:`TYPE_LSB] == nocLinkPkg::HEAD) begin
                                pickVc = `VC_W'(idx);
                                pickFound = 1'b1;
                        end
                end
        end

        assign ejValid = (state == nocLinkPkg::EJ_PKT) && notEmpty[curVc];
        assign ejFlit  = headFlit[curVc];
        assign ejVc    = curVc;
        assign ejPop   = ejValid && ejReady;

        // One ack per popped flit, lock held for the whole packet.
        always_comb begin
                linkAck  = '0;
                linkLock = '0;
                if (state == nocLinkPkg::EJ_PKT) begin
                        linkLock[curVc] = 1'b1;
                        linkAck[curVc]  = ejPop;
                end
        end

        always_ff @(posedge clk) begin
                if (rst) begin
                        state <= nocLinkPkg::EJ_IDLE;
                        curVc <= '0;
                        rrPtr <= '0;
                end else if (state == nocLinkPkg::EJ_IDLE) begin
                        if (pickFound) begin
                                state <= nocLinkPkg::EJ_PKT;
                                curVc <= pickVc;
                                rrPtr <= (pickVc == `VC_W'(`VC_N - 1)) ? '0 : pickVc + 1'b1;
                        end
                end else if (ejPop && ejFlit[`TYPE_MSB:`TYPE_LSB] == nocLinkPkg::TAIL) begin
                        state <= nocLinkPkg::EJ_IDLE;
                end
        end

endmodule

`default_nettype wire

// ==== hdl/nocLink.sv ====
// One link, two VCs, fixed-length packets; vcLock is a status output only.
`timescale 1ns/1ps
`default_nettype none

`include "nocLink_params.svh"

module nocLink (
        input  wire logic                             clk,
        input  wire logic                             rst,
        input  wire logic [`VC_N-1:0][`FLIT_W-1:0]    injFlit,
        input  wire logic [`VC_N-1:0]                 injValid,
        output logic      [`VC_N-1:0]                 injReady,
        output logic      [`FLIT_W-1:0]               ejFlit,
        output logic                                  ejValid,
        output logic      [`VC_W-1:0]                 ejVc,
        input  wire logic                             ejReady,
        output logic      [`VC_N-1:0]                 vcLock
);

        logic [`FLIT_W-1:0] sendFlit;
        logic               sendValid;
        logic [`VC_W-1:0]   sendVc;
        logic [`VC_N-1:0]   vcReady;
        logic [`FLIT_W-1:0] linkFlit;
        logic               linkValid;
        logic [`VC_W-1:0]   linkVc;
        logic [`VC_N-1:0]   linkAck;
        logic [`VC_N-1:0]   linkLock;

        // Upstream side.
        vcArbiter vcArbiter_inst (
                .clk       (clk),
                .rst       (rst),
                .injFlit   (injFlit),
                .injValid  (injValid),
                .injReady  (injReady),
                .vcReady   (vcReady),
                .sendFlit  (sendFlit),
                .sendValid (sendValid),
                .sendVc    (sendVc)
        );

        outputChannel outputChannel_inst (
                .clk       (clk),
                .rst       (rst),
                .sendFlit  (sendFlit),
                .sendValid (sendValid),
                .sendVc    (sendVc),
                .vcReady   (vcReady),
                .vcLock    (vcLock),
                .linkFlit  (linkFlit),
                .linkValid (linkValid),
                .linkVc    (linkVc),
                .linkAck   (linkAck),
                .linkLock  (linkLock)
        );

        // Downstream side.
        vcInputBuffer vcInputBuffer_inst (
                .clk       (clk),
                .rst       (rst),
                .linkFlit  (linkFlit),
                .linkValid (linkValid),
                .linkVc    (linkVc),
                .linkAck   (linkAck),
                .linkLock  (linkLock),
                .ejFlit    (ejFlit),
                .ejValid   (ejValid),
                .ejVc      (ejVc),
                .ejReady   (ejReady)
        );

endmodule

`default_nettype wire

// ==== tests/nocLinkTb.sv ====
// Random traffic from a fixed seed; the run stops at the first mismatch, stall or timeout.
`timescale 1ns/1ps
`default_nettype none

`include "nocLink_params.svh"

module nocLinkTb;

        localparam int PKTS_PER_VC = 60;
        localparam int BURST_LEN   = 40;
        localparam int STALL_LIMIT = 400;

        logic                          clk = 1'b0;
        logic                          rst = 1'b1;
        logic [`VC_N-1:0][`FLIT_W-1:0] injFlit = '0;
        logic [`VC_N-1:0]              injValid = '0;
        logic [`VC_N-1:0]              injReady;
        logic [`FLIT_W-1:0]            ejFlit;
        logic                          ejValid;
        logic [`VC_W-1:0]              ejVc;
        logic                          ejReady = 1'b0;
        logic [`VC_N-1:0]              vcLock;

        // Model of per-VC flits accepted at injection and not yet ejected.
        logic [`FLIT_W-1:0] modelQ [`VC_N][$];
        int                 flitIdx [`VC_N] = '{default: 0};
        int                 pktSent [`VC_N] = '{default: 0};
        int                 gap [`VC_N] = '{default: 0};
        int                 burstCnt [`VC_N] = '{default: 0};
        int                 burstLeft = 0;
        int                 stallCycles = 0;
        int                 ejIdx = 0;
        logic               ejInPkt = 1'b0;
        logic               injInPkt = 1'b0;
        logic [`VC_W-1:0]   ejPktVc = '0;
        logic [`VC_W-1:0]   injPktVc = '0;
        logic               firstCycle = 1'b1;

        nocLink nocLink_inst (.*);

        always #50 clk = ~clk;

        task automatic failRun(input string why);
                $display("%s", why);
                $display("Some tests failed");
                $fatal(1, "stopped at the first error");
        endtask

        task automatic checkEq(input logic [63:0] actual, input logic [63:0] expected,
                               input string msg);
                if (actual !== expected) begin
                        failRun($sformatf("CHECK FAILED at %0t: %s (got %0h, want %0h)",
                                          $time, msg, actual, expected));
                end
        endtask

        // Position in the packet gives the flit type.
        function automatic nocLinkPkg::flitType_e typeAt(input int idx);
                if (idx == 0) begin
                        return nocLinkPkg::HEAD;
                end else if (idx == `PKT_LEN - 1) begin
                        return nocLinkPkg::TAIL;
                end
                return nocLinkPkg::BODY;
        endfunction

        // Packets still to inject plus flits still in flight.
        function automatic int workLeft();
                int n = 0;
                for (int v = 0; v < `VC_N; v++) begin
                        n += (PKTS_PER_VC - pktSent[v]) + modelQ[v].size();
                end
                return n;
        endfunction

        // ============================================================
        // Checks sampled and stimulus driven on the rising edge
        // ============================================================
        always @(posedge clk) begin
                logic [`FLIT_W-1:0] expFlit;
                if (!rst) begin
                        if (firstCycle) begin
                                checkEq(64'(injReady), 64'd0, "injReady after reset");
                                checkEq(64'(ejValid), 64'd0, "ejValid after reset");
                                checkEq(64'(vcLock), 64'd0, "vcLock after reset");
                                firstCycle = 1'b0;
                        end
                        checkEq(64'($countones(injReady) > 1), 64'd0, "injReady on two VCs");
                        if (injInPkt) begin
                                checkEq(64'(injReady & ~(`VC_N'(1) << injPktVc)), 64'd0,
                                        "injReady on another VC inside a packet");
                        end
                        if (ejValid && ejReady) begin
                                checkEq(64'(modelQ[ejVc].size() == 0), 64'd0,
                                        "flit ejected with nothing injected on its VC");
                                expFlit = modelQ[ejVc].pop_front();
                                checkEq(64'(ejFlit), 64'(expFlit), "ejected flit data");
                                if (!ejInPkt) begin
                                        ejPktVc = ejVc;
                                        ejIdx = 0;
                                end
                                checkEq(64'(ejVc), 64'(ejPktVc), "ejVc changed inside a packet");
                                checkEq(64'(ejFlit[`TYPE_MSB:`TYPE_LSB]), 64'(typeAt(ejIdx)),
                                        "flit type at ejection");
                                ejInPkt = (ejIdx != `PKT_LEN - 1);
                                ejIdx++;
                                stallCycles = 0;
                        end else if (workLeft() != 0) begin
                                stallCycles++;
                                if (stallCycles > STALL_LIMIT) begin
                                        failRun("ejection stalled, credits are not coming back");
                                end
                        end
                        for (int v = 0; v < `VC_N; v++) begin
                                if (injValid[v] && injReady[v]) begin
                                        modelQ[v].push_back(injFlit[v]);
                                        if (burstLeft > 0) begin
                                                burstCnt[v]++;
                                                checkEq(64'(burstCnt[v] > `FIFO_DEPTH + `PKT_LEN),
                                                        64'd0, "too many flits taken under back-pressure");
                                        end
                                        if (flitIdx[v] == 0) begin
                                                injInPkt = 1'b1;
                                                injPktVc = `VC_W'(v);
                                        end
                                        if (flitIdx[v] == `PKT_LEN - 1) begin
                                                injInPkt = 1'b0;
                                                flitIdx[v] = 0;
                                                pktSent[v]++;
                                                gap[v] = $urandom % 6;
                                                injValid[v] <= 1'b0;
                                        end else begin
                                                flitIdx[v]++;
                                                injFlit[v] <= {typeAt(flitIdx[v]), $urandom};
                                        end
                                end else if (!injValid[v] && pktSent[v] < PKTS_PER_VC) begin
                                        if (gap[v] > 0) begin
                                                gap[v]--;
                                        end else begin
                                                injValid[v] <= 1'b1;
                                                injFlit[v] <= {nocLinkPkg::HEAD, $urandom};
                                        end
                                end
                        end
                        // Ejection back-pressure is random with long bursts held low.
                        if (burstLeft > 1) begin
                                burstLeft--;
                        end else if (burstLeft == 0 && $urandom % 64 == 0) begin
                                burstLeft = BURST_LEN;
                                burstCnt = '{default: 0};
                        end else begin
                                burstLeft = 0;
                        end
                        ejReady <= (burstLeft > 0) ? 1'b0 : ($urandom % 100 < 60);
                end
        end

        initial begin
                int cycles;
                void'($urandom(32'h2029_3175));
                repeat (2) @(posedge clk);
                rst <= 1'b0;
                cycles = 0;
                while ((workLeft() != 0 || ejInPkt) && cycles < 200000) begin
                        @(negedge clk);
                        cycles++;
                end
                if (workLeft() != 0 || ejInPkt) begin
                        failRun("timeout waiting for ejection to drain");
                end else begin
                        $display("All tests passed");
                        $finish;
                end
        end

endmodule

`default_nettype wire

// ==== nocLink.f ====
+incdir+hdl
hdl/nocLinkPkg.sv
hdl/vcArbiter.sv
hdl/outputChannel.sv
hdl/vcInputBuffer.sv
hdl/nocLink.sv
tests/nocLinkTb.sv

// ==== Makefile ====
# Verilator build and run of the NoC link testbench.
TOP := nocLinkTb

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory"
	@echo "make help   list these targets"

obj_dir/V$(TOP): nocLink.f hdl/*.sv hdl/*.svh tests/*.sv
	verilator --binary --timing -f nocLink.f --top-module $(TOP) -o V$(TOP)

test: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf obj_dir
